// ==== alu.sv ====
module alu
    import rv_isa_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  alu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result
);

    logic [REG_ADDR_W-1:0] shamt;

    assign shamt = b[REG_ADDR_W-1:0];  // Shift amount fits a register index

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_ANDN: result = a & ~b;
            ALU_ORN:  result = a | ~b;
            ALU_XNOR: result = ~(a ^ b);
            ALU_MIN:  result = ($signed(a) < $signed(b)) ? a : b;
            ALU_MAX:  result = ($signed(a) > $signed(b)) ? a : b;
            ALU_MINU: result = (a < b) ? a : b;
            ALU_MAXU: result = (a > b) ? a : b;
            // A shift by XLEN gives zero, so shamt 0 still returns a
            ALU_ROL:  result = (a << shamt) | (a >> (XLEN - shamt));
            ALU_ROR:  result = (a >> shamt) | (a << (XLEN - shamt));
            default:  result = '0;
        endcase
    end

endmodule

// ==== compile.f ====
rv_isa_pkg.sv
pipe_ctrl_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
alu.sv
execute_stage.sv
result_stage.sv
rv_pipeline_top.sv
tb_rv_pipeline.sv

// ==== decode_stage.sv ====
module decode_stage
    import rv_isa_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [XLEN-1:0]       ifid_pc,
    input  logic [31:0]           ifid_instr,
    input  logic                  redirect,
    output logic                  stall,
    output logic [REG_ADDR_W-1:0] rf_rs1_addr,
    output logic [REG_ADDR_W-1:0] rf_rs2_addr,
    input  logic [XLEN-1:0]       rf_rs1_data,
    input  logic [XLEN-1:0]       rf_rs2_data,
    output logic [XLEN-1:0]       idex_pc,
    output logic [XLEN-1:0]       idex_rs1_data,
    output logic [XLEN-1:0]       idex_rs2_data,
    output logic [XLEN-1:0]       idex_imm,
    output logic [REG_ADDR_W-1:0] idex_rs1,
    output logic [REG_ADDR_W-1:0] idex_rs2,
    output logic [REG_ADDR_W-1:0] idex_rd,
    output alu_op_e               idex_alu_op,
    output logic                  idex_alu_src,
    output logic                  idex_reg_write,
    output logic                  idex_mem_read,
    output logic                  idex_mem_write,
    output logic                  idex_mem_to_reg,
    output logic                  idex_is_beq
);

    logic [6:0]            opcode;
    logic [6:0]            funct7;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm_i, imm_s, imm_b, imm;
    alu_op_e               alu_op;
    logic                  alu_src, reg_write, mem_read, mem_write, mem_to_reg, is_beq;
    logic                  use_rs2;

    assign opcode      = ifid_instr[6:0];
    assign rd          = ifid_instr[11:7];
    assign funct3      = ifid_instr[14:12];
    assign rf_rs1_addr = ifid_instr[19:15];
    assign rf_rs2_addr = ifid_instr[24:20];
    assign funct7      = ifid_instr[31:25];

    assign imm_i = {{20{ifid_instr[31]}}, ifid_instr[31:20]};
    assign imm_s = {{20{ifid_instr[31]}}, ifid_instr[31:25], ifid_instr[11:7]};
    assign imm_b = {{20{ifid_instr[31]}}, ifid_instr[7], ifid_instr[30:25],
                    ifid_instr[11:8], 1'b0};

    // Anything not recognised falls through with all control low
    always_comb begin
        alu_op     = ALU_ADD;
        alu_src    = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        is_beq     = 1'b0;
        use_rs2    = 1'b0;
        imm        = imm_i;
        case (opcode)
            OPC_OP: begin
                reg_write = 1'b1;
                use_rs2   = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}:   alu_op = ALU_ADD;
                    {F7_ALT, F3_ADD}:    alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}:   alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:    alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}:   alu_op = ALU_XOR;
                    {F7_BASE, F3_SLL}:   alu_op = ALU_SLL;
                    {F7_BASE, F3_SR}:    alu_op = ALU_SRL;
                    {F7_ALT, F3_SR}:     alu_op = ALU_SRA;
                    {F7_ALT, F3_AND}:    alu_op = ALU_ANDN;
                    {F7_ALT, F3_OR}:     alu_op = ALU_ORN;
                    {F7_ALT, F3_XOR}:    alu_op = ALU_XNOR;
                    {F7_MINMAX, F3_XOR}: alu_op = ALU_MIN;
                    {F7_MINMAX, F3_SR}:  alu_op = ALU_MINU;
                    {F7_MINMAX, F3_OR}:  alu_op = ALU_MAX;
                    {F7_MINMAX, F3_AND}: alu_op = ALU_MAXU;
                    {F7_ROT, F3_SLL}:    alu_op = ALU_ROL;
                    {F7_ROT, F3_SR}:     alu_op = ALU_ROR;
                    default: begin
                        reg_write = 1'b0;
                        use_rs2   = 1'b0;
                    end
                endcase
            end
            OPC_OP_IMM: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                case (funct3)
                    F3_ADD:  alu_op = ALU_ADD;
                    F3_AND:  alu_op = ALU_AND;
                    F3_OR:   alu_op = ALU_OR;
                    F3_XOR:  alu_op = ALU_XOR;
                    default: begin
                        reg_write = 1'b0;
                        alu_src   = 1'b0;
                    end
                endcase
            end
            OPC_LOAD: begin
                if (funct3 == F3_WORD) begin
                    reg_write  = 1'b1;
                    mem_read   = 1'b1;
                    mem_to_reg = 1'b1;
                    alu_src    = 1'b1;
                end
            end
            OPC_STORE: begin
                imm = imm_s;
                if (funct3 == F3_WORD) begin
                    mem_write = 1'b1;
                    alu_src   = 1'b1;
                    use_rs2   = 1'b1;  // Store data
                end
            end
            OPC_BRANCH: begin
                imm = imm_b;
                if (funct3 == F3_BEQ) begin
                    is_beq  = 1'b1;
                    use_rs2 = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // Load in EX feeding the instruction in decode
    assign stall = idex_mem_read && (idex_rd != '0) &&
                   ((idex_rd == rf_rs1_addr) || (use_rs2 && (idex_rd == rf_rs2_addr)));

    always_ff @(posedge clk) begin
        if (rst || redirect || stall) begin
            idex_alu_op     <= ALU_ADD;  // Bubble
            idex_alu_src    <= 1'b0;
            idex_reg_write  <= 1'b0;
            idex_mem_read   <= 1'b0;
            idex_mem_write  <= 1'b0;
            idex_mem_to_reg <= 1'b0;
            idex_is_beq     <= 1'b0;
        end else begin
            idex_alu_op     <= alu_op;
            idex_alu_src    <= alu_src;
            idex_reg_write  <= reg_write;
            idex_mem_read   <= mem_read;
            idex_mem_write  <= mem_write;
            idex_mem_to_reg <= mem_to_reg;
            idex_is_beq     <= is_beq;
        end
    end

    always_ff @(posedge clk) begin
        idex_pc       <= ifid_pc;
        idex_rs1_data <= rf_rs1_data;
        idex_rs2_data <= rf_rs2_data;
        idex_imm      <= imm;
        idex_rs1      <= rf_rs1_addr;
        idex_rs2      <= rf_rs2_addr;
        idex_rd       <= rd;
    end

endmodule

// ==== execute_stage.sv ====
module execute_stage
    import pipe_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] idex_pc,
    input  logic [XLEN-1:0] idex_rs1_data,
    input  logic [XLEN-1:0] idex_rs2_data,
    input  logic [XLEN-1:0] idex_imm,
    input  logic [4:0]      idex_rs1,
    input  logic [4:0]      idex_rs2,
    input  logic [4:0]      idex_rd,
    input  alu_op_e         idex_alu_op,
    input  logic            idex_alu_src,
    input  logic            idex_reg_write,
    input  logic            idex_mem_read,
    input  logic            idex_mem_write,
    input  logic            idex_mem_to_reg,
    input  logic            idex_is_beq,
    input  logic [XLEN-1:0] memwb_result,
    input  logic [4:0]      memwb_rd,
    input  logic            memwb_reg_write,
    output logic            redirect,
    output logic [XLEN-1:0] redirect_pc,
    output logic [XLEN-1:0] exmem_alu_result,
    output logic [XLEN-1:0] exmem_store_data,
    output logic [4:0]      exmem_rd,
    output logic            exmem_reg_write,
    output logic            exmem_mem_read,
    output logic            exmem_mem_write,
    output logic            exmem_mem_to_reg
);

    fwd_sel_e        fwd_a, fwd_b;
    logic [XLEN-1:0] op_a, op_b, alu_b, alu_result;

    // Younger result in EX/MEM takes precedence
    function automatic fwd_sel_e fwd_select(input logic [4:0] src);
        if (src == 5'd0) begin
            return FWD_NONE;
        end else if (exmem_reg_write && (exmem_rd == src)) begin
            return FWD_EXMEM;
        end else if (memwb_reg_write && (memwb_rd == src)) begin
            return FWD_MEMWB;
        end
        return FWD_NONE;
    endfunction

    function automatic logic [XLEN-1:0] fwd_value(input fwd_sel_e sel,
                                                  input logic [XLEN-1:0] rf_val);
        case (sel)
            FWD_EXMEM: return exmem_alu_result;
            FWD_MEMWB: return memwb_result;
            default:   return rf_val;
        endcase
    endfunction

    always_comb begin
        fwd_a = fwd_select(idex_rs1);
        fwd_b = fwd_select(idex_rs2);
        op_a  = fwd_value(fwd_a, idex_rs1_data);
        op_b  = fwd_value(fwd_b, idex_rs2_data);
    end

    assign alu_b = idex_alu_src ? idex_imm : op_b;

    alu alu_i (
        .op     (idex_alu_op),
        .a      (op_a),
        .b      (alu_b),
        .result (alu_result)
    );

    assign redirect    = idex_is_beq && (op_a == op_b);
    assign redirect_pc = idex_pc + idex_imm;  // B immediate

    always_ff @(posedge clk) begin
        if (rst) begin
            exmem_reg_write  <= 1'b0;
            exmem_mem_read   <= 1'b0;
            exmem_mem_write  <= 1'b0;
            exmem_mem_to_reg <= 1'b0;
        end else begin
            exmem_reg_write  <= idex_reg_write;
            exmem_mem_read   <= idex_mem_read;
            exmem_mem_write  <= idex_mem_write;
            exmem_mem_to_reg <= idex_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        exmem_alu_result <= alu_result;
        exmem_store_data <= op_b;  // Forwarded rs2
        exmem_rd         <= idex_rd;
    end

endmodule

// ==== fetch_stage.sv ====
module fetch_stage
    import rv_isa_pkg::*;
    import pipe_ctrl_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            redirect,
    input  logic [XLEN-1:0] redirect_pc,
    input  logic [31:0]     imem_rdata,
    output logic [XLEN-1:0] imem_addr,
    output logic [XLEN-1:0] ifid_pc,
    output logic [31:0]     ifid_instr
);

    logic [XLEN-1:0] pc;

    assign imem_addr = pc;  // Same-cycle fetch

    // Redirect wins over a load-use hold
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            ifid_instr <= NOP_INSTR;  // Squash the wrong-path word
        end else if (!stall) begin
            ifid_instr <= imem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifid_pc <= pc;
        end
    end

endmodule

// ==== pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

    localparam int XLEN = 32;

    // Seventeen operations, so five bits
    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ANDN, ALU_ORN, ALU_XNOR,
        ALU_MIN, ALU_MAX, ALU_MINU, ALU_MAXU,
        ALU_ROL, ALU_ROR
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

endpackage

// ==== reg_file.sv ====
module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [32];
    logic        wr_live;

    assign wr_live = wr_en && (wr_addr != 5'd0);  // x0 stays zero

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through so decode sees this cycle's write-back
    assign rs1_data = (wr_live && (wr_addr == rs1_addr)) ? wr_data : regs[rs1_addr];
    assign rs2_data = (wr_live && (wr_addr == rs2_addr)) ? wr_data : regs[rs2_addr];

endmodule

// ==== result_stage.sv ====
module result_stage
    import pipe_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] exmem_alu_result,
    input  logic [XLEN-1:0] exmem_store_data,
    input  logic [4:0]      exmem_rd,
    input  logic            exmem_reg_write,
    input  logic            exmem_mem_read,
    input  logic            exmem_mem_write,
    input  logic            exmem_mem_to_reg,
    input  logic [XLEN-1:0] dmem_rdata,
    output logic [XLEN-1:0] dmem_addr,
    output logic [XLEN-1:0] dmem_wdata,
    output logic            dmem_wen,
    output logic            dmem_ren,
    output logic [XLEN-1:0] memwb_result,
    output logic [4:0]      memwb_rd,
    output logic            memwb_reg_write
);

    assign dmem_addr  = exmem_alu_result;
    assign dmem_wdata = exmem_store_data;
    assign dmem_wen   = exmem_mem_write;
    assign dmem_ren   = exmem_mem_read;

    always_ff @(posedge clk) begin
        if (rst) begin
            memwb_reg_write <= 1'b0;
        end else begin
            memwb_reg_write <= exmem_reg_write;
        end
    end

    // Load data or ALU result, picked once here
    always_ff @(posedge clk) begin
        memwb_result <= exmem_mem_to_reg ? dmem_rdata : exmem_alu_result;
        memwb_rd     <= exmem_rd;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then decide pass or fail from the simulation log
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_pipeline \
    -f compile.f -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q "TESTS FAILED" sim.log && exit 1 || grep -q "TESTS PASSED" sim.log || exit 1

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int REG_ADDR_W = 5;

    // Plain ADDI x0,x0,0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // Zbb reuses these funct3 slots under its own funct7
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,  // Also ROL
        F3_WORD = 3'b010,  // LW and SW width
        F3_XOR  = 3'b100,  // Also XNOR, MIN
        F3_SR   = 3'b101,  // SRL, SRA, MINU, ROR
        F3_OR   = 3'b110,  // Also ORN, MAX
        F3_AND  = 3'b111   // Also ANDN, MAXU
    } funct3_e;

    localparam logic [2:0] F3_BEQ = 3'b000;

    typedef enum logic [6:0] {
        F7_BASE   = 7'b0000000,
        F7_ALT    = 7'b0100000,  // SUB, SRA, ANDN, ORN, XNOR
        F7_MINMAX = 7'b0000101,
        F7_ROT    = 7'b0110000
    } funct7_e;

endpackage

// ==== rv_pipeline_top.sv ====
module rv_pipeline_top
    import pipe_ctrl_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [31:0]     imem_rdata,
    input  logic [XLEN-1:0] dmem_rdata,
    output logic [XLEN-1:0] imem_addr,
    output logic [XLEN-1:0] dmem_addr,
    output logic [XLEN-1:0] dmem_wdata,
    output logic            dmem_wen,
    output logic            dmem_ren
);

    // Stage ports share these names, so the stages hook up by name
    logic            stall, redirect;
    logic [XLEN-1:0] redirect_pc, ifid_pc;
    logic [31:0]     ifid_instr;
    logic [4:0]      rf_rs1_addr, rf_rs2_addr;
    logic [XLEN-1:0] rf_rs1_data, rf_rs2_data;

    logic [XLEN-1:0] idex_pc, idex_rs1_data, idex_rs2_data, idex_imm;
    logic [4:0]      idex_rs1, idex_rs2, idex_rd;
    alu_op_e         idex_alu_op;
    logic            idex_alu_src, idex_reg_write, idex_mem_read;
    logic            idex_mem_write, idex_mem_to_reg, idex_is_beq;

    logic [XLEN-1:0] exmem_alu_result, exmem_store_data;
    logic [4:0]      exmem_rd;
    logic            exmem_reg_write, exmem_mem_read, exmem_mem_write, exmem_mem_to_reg;

    logic [XLEN-1:0] memwb_result;
    logic [4:0]      memwb_rd;
    logic            memwb_reg_write;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_i (.*);

    decode_stage decode_stage_i (.*);

    reg_file reg_file_i (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rf_rs1_addr),
        .rs2_addr (rf_rs2_addr),
        .wr_en    (memwb_reg_write),  // Write-back port
        .wr_addr  (memwb_rd),
        .wr_data  (memwb_result),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data)
    );

    execute_stage execute_stage_i (.*);

    result_stage result_stage_i (.*);

endmodule

// ==== tb_rv_pipeline.sv ====
module tb_rv_pipeline;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          IMEM_WORDS = 256;
    localparam int          DMEM_WORDS = 256;
    localparam logic [31:0] NOP_WORD   = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [6:0]  OP_R       = 7'b0110011;
    localparam logic [6:0]  OP_I       = 7'b0010011;
    localparam logic [6:0]  OP_LOAD    = 7'b0000011;
    localparam logic [6:0]  OP_STORE   = 7'b0100011;
    localparam logic [6:0]  OP_BR      = 7'b1100011;

    // {funct7, funct3} in the order add sub and or xor sll srl sra andn orn xnor
    // min max minu maxu rol ror
    localparam logic [9:0] R_OPS [17] = '{
        10'b0000000_000, 10'b0100000_000, 10'b0000000_111, 10'b0000000_110,
        10'b0000000_100, 10'b0000000_001, 10'b0000000_101, 10'b0100000_101,
        10'b0100000_111, 10'b0100000_110, 10'b0100000_100, 10'b0000101_100,
        10'b0000101_110, 10'b0000101_101, 10'b0000101_111, 10'b0110000_001,
        10'b0110000_101
    };
    localparam logic [2:0] I_F3 [4] = '{3'b000, 3'b111, 3'b110, 3'b100};  // addi andi ori xori

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] imem_rdata, dmem_rdata, imem_addr, dmem_addr, dmem_wdata;
    logic        dmem_wen, dmem_ren;

    logic [31:0] imem [IMEM_WORDS];
    string       instr_test [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] model_mem [DMEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    string       exp_name [$];
    integer      seed;
    int          n_instr = 0;
    int          store_off = 'h200;  // Stores land above the operand words

    rv_pipeline_top #(.RESET_PC(32'h0)) rv_pipeline_top_i (.*);

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [9:0] f7f3, input logic [4:0] rd, rs1, rs2);
        return {f7f3[9:3], rs2, rs1, f7f3[2:0], rd, OP_R};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [4:0] rs1, rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OP_BR};
    endfunction

    task automatic emit(input logic [31:0] instr, input string name);
        imem[n_instr]       = instr;
        instr_test[n_instr] = name;
        n_instr++;
    endtask

    task automatic emit_store(input logic [4:0] rs2, input string name);
        logic [11:0] off;
        off = 12'(store_off);
        emit({off[11:5], rs2, 5'd0, 3'b010, off[4:0], OP_STORE}, name);
        store_off += 4;
    endtask

    task automatic build_programs();
        logic [31:0] rnd;
        for (int p = 0; p < 2; p++) begin
            emit(enc_i(OP_LOAD, 3'b010, 5'd1, 5'd0, 12'(8 * p)), "alu");
            emit(enc_i(OP_LOAD, 3'b010, 5'd2, 5'd0, 12'(8 * p + 4)), "alu");
            for (int k = 0; k < 17; k++) begin
                emit(enc_r(R_OPS[k], 5'd3, 5'd1, 5'd2), "alu");
                emit_store(5'd3, "alu");
            end
        end
        for (int k = 0; k < 4; k++) begin
            rnd = $random(seed);
            emit(enc_i(OP_I, I_F3[k], 5'd4, 5'd1, rnd[11:0]), "alu_imm");
            emit_store(5'd4, "alu_imm");
        end
        emit(enc_r(R_OPS[0], 5'd5, 5'd1, 5'd2), "forwarding");
        emit(enc_r(R_OPS[1], 5'd6, 5'd5, 5'd1), "forwarding");  // Distance 1
        emit(enc_r(R_OPS[3], 5'd7, 5'd5, 5'd6), "forwarding");  // Distances 2 and 1
        emit(enc_r(R_OPS[2], 5'd9, 5'd5, 5'd7), "forwarding");  // x5 via register file
        emit_store(5'd6, "forwarding");
        emit_store(5'd7, "forwarding");
        emit_store(5'd9, "forwarding");
        emit(enc_i(OP_LOAD, 3'b010, 5'd10, 5'd0, 12'd16), "load_use");
        emit(enc_r(R_OPS[0], 5'd11, 5'd10, 5'd1), "load_use");
        emit_store(5'd11, "load_use");
        emit(enc_i(OP_LOAD, 3'b010, 5'd12, 5'd0, 12'd20), "load_use");
        emit_store(5'd12, "load_use");  // Store data from the load
        emit(enc_i(OP_I, 3'b000, 5'd13, 5'd0, 12'd5), "branch");
        emit(enc_i(OP_I, 3'b000, 5'd14, 5'd0, 12'd5), "branch");
        emit(enc_b(5'd13, 5'd14, 13'd12), "branch");  // Taken over two stores
        emit_store(5'd13, "branch");
        emit_store(5'd14, "branch");
        emit_store(5'd1, "branch");
        emit(enc_i(OP_I, 3'b000, 5'd15, 5'd0, 12'd6), "branch");
        emit(enc_b(5'd13, 5'd15, 13'd8), "branch");   // Not taken
        emit_store(5'd15, "branch");
        emit_store(5'd13, "branch");
        emit(enc_i(OP_I, 3'b000, 5'd0, 5'd1, 12'd123), "x0_write");
        emit(enc_r(R_OPS[0], 5'd0, 5'd1, 5'd2), "x0_write");
        emit_store(5'd0, "x0_write");
    endtask

    function automatic logic [31:0] r_result(input logic [9:0] f7f3, input logic [31:0] a, b);
        logic [4:0]  sh;
        logic [63:0] dbl;
        sh  = b[4:0];
        dbl = {a, a};  // Rotates read a window of the doubled word
        case (f7f3)
            10'b0000000_000: return a + b;
            10'b0100000_000: return a - b;
            10'b0000000_111: return a & b;
            10'b0000000_110: return a | b;
            10'b0000000_100: return a ^ b;
            10'b0000000_001: return a << sh;
            10'b0000000_101: return a >> sh;
            10'b0100000_101: return $signed(a) >>> sh;
            10'b0100000_111: return a & ~b;
            10'b0100000_110: return a | ~b;
            10'b0100000_100: return ~(a ^ b);
            10'b0000101_100: return ($signed(a) < $signed(b)) ? a : b;
            10'b0000101_110: return ($signed(a) < $signed(b)) ? b : a;
            10'b0000101_101: return (a < b) ? a : b;
            10'b0000101_111: return (a < b) ? b : a;
            10'b0110000_001: return dbl[63 - sh -: 32];
            default:         return dbl[sh +: 32];
        endcase
    endfunction

    // Sequential ISA execution collecting the expected stores in order
    task automatic run_model();
        logic [31:0] x [32];
        logic [31:0] pc, next_pc, ins, a, b, imm_i, addr;
        int          steps;
        for (int r = 0; r < 32; r++) begin
            x[r] = '0;
        end
        pc    = '0;
        steps = 0;
        while (pc < 32'(4 * n_instr) && steps < 4 * IMEM_WORDS) begin
            ins     = imem[pc[9:2]];
            a       = x[ins[19:15]];
            b       = x[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            next_pc = pc + 32'd4;
            case (ins[6:0])
                OP_R: x[ins[11:7]] = r_result({ins[31:25], ins[14:12]}, a, b);
                OP_I: begin
                    case (ins[14:12])
                        3'b000:  x[ins[11:7]] = a + imm_i;
                        3'b111:  x[ins[11:7]] = a & imm_i;
                        3'b110:  x[ins[11:7]] = a | imm_i;
                        default: x[ins[11:7]] = a ^ imm_i;
                    endcase
                end
                OP_LOAD: begin
                    addr         = a + imm_i;
                    x[ins[11:7]] = model_mem[addr[9:2]];
                end
                OP_STORE: begin
                    addr                 = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    model_mem[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    exp_name.push_back(instr_test[pc[9:2]]);
                end
                OP_BR: begin
                    if (a == b) begin
                        next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                default: ;
            endcase
            x[0] = '0;
            pc   = next_pc;
            steps++;
        end
    endtask

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_store();
        string       name;
        logic [31:0] addr;
        logic [31:0] data;
        assert (exp_addr.size() != 0)
        else begin
            $display("store to %h seen after the last expected store", dmem_addr);
            abort_run();
        end
        name = exp_name.pop_front();
        addr = exp_addr.pop_front();
        data = exp_data.pop_front();
        assert (dmem_addr == addr)
        else begin
            $display("error %s store address expected %h actual %h", name, addr, dmem_addr);
            abort_run();
        end
        assert (dmem_wdata == data)
        else begin
            $display("error %s store data expected %h actual %h", name, data, dmem_wdata);
            abort_run();
        end
        dmem[dmem_addr[9:2]] = dmem_wdata;
    endtask

    // Memory answers settle on the falling edge ahead of the next rising one
    task automatic serve_memories();
        imem_rdata = (imem_addr < 32'(4 * IMEM_WORDS)) ? imem[imem_addr[9:2]] : NOP_WORD;
        dmem_rdata = dmem[dmem_addr[9:2]];
    endtask

    task automatic step_cycle();
        @(negedge clk);
        if (dmem_wen) begin
            check_store();
        end
        serve_memories();
    endtask

    initial begin
        int cycles;
        int limit;
        rst        = 1'b1;
        imem_rdata = NOP_WORD;
        dmem_rdata = '0;
        seed       = 76;
        cycles     = 0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]      = $random(seed);
            model_mem[i] = dmem[i];
        end
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i]       = NOP_WORD;
            instr_test[i] = "idle";
        end
        build_programs();
        run_model();
        limit = 3 * n_instr + 50;
        repeat (10) begin
            @(negedge clk);
            assert (dmem_wen === 1'b0 && dmem_ren === 1'b0)
            else begin
                $display("data memory enabled during reset");
                abort_run();
            end
            serve_memories();
        end
        rst = 1'b0;
        assert (imem_addr == 32'h0)
        else begin
            $display("error reset fetch address expected %h actual %h", 32'h0, imem_addr);
            abort_run();
        end
        @(negedge clk);
        assert (dmem_wen === 1'b0 && dmem_ren === 1'b0)
        else begin
            $display("data memory enabled in the first cycle after reset");
            abort_run();
        end
        serve_memories();
        while (exp_addr.size() != 0 && cycles < limit) begin
            step_cycle();
            cycles++;
        end
        repeat (5) begin
            step_cycle();  // Catch a stray store past the end
        end
        if (exp_addr.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("programs did not finish within %0d cycles", limit);
            abort_run();
        end
    end

endmodule
